// File: verilog/fdc_pkg.sv
/*
 * Shared definitions for the WD1793-style controller.
 * Only fixed-geometry images in track-side-sector layout are covered.
 * Timing constants count ce cycles, not clk_sys cycles.
 */
package fdc_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [1:0]  reg_addr_t;
	typedef logic [19:0] img_addr_t;   // 1 MB image max
	typedef logic [31:0] lba_t;
	typedef logic [10:0] buf_addr_t;
	typedef logic [1:0]  blk_idx_t;    // 512-byte block inside the buffer
	typedef logic [10:0] sec_len_t;
	typedef logic [2:0]  size_code_t;
	typedef logic [1:0]  wd_size_t;    // length is 128 << code

	// register map, status and command share address 0
	localparam reg_addr_t A_STATUS  = 2'd0;
	localparam reg_addr_t A_COMMAND = 2'd0;
	localparam reg_addr_t A_TRACK   = 2'd1;
	localparam reg_addr_t A_SECTOR  = 2'd2;
	localparam reg_addr_t A_DATA    = 2'd3;

	// upper nibble of the command byte
	localparam logic [3:0] CMD_RESTORE   = 4'h0;
	localparam logic [3:0] CMD_SEEK      = 4'h1;
	localparam logic [3:0] CMD_READ      = 4'h8;
	localparam logic [3:0] CMD_WRITE     = 4'hA;
	localparam logic [3:0] CMD_FORCE_INT = 4'hD;

	// ====================================================================
	// timing
	// ====================================================================
	localparam int SETTLE_CYCLES   = 4000;
	localparam int SEEK_DELAY      = 1023;
	localparam int BYTE_DELAY      = 15;
	localparam int WATCHDOG_CYCLES = 4096;
	localparam int ACK_SYNC_DEPTH  = 6;

	typedef enum logic [3:0] {
		S_IDLE,
		S_SEARCH,
		S_FETCH_START,
		S_FETCH_WAIT,
		S_BYTE_DELAY,
		S_BYTE_WAIT,
		S_FLUSH_START,
		S_FLUSH_WAIT,
		S_SETTLE,
		S_END
	} seq_state_t;

endpackage

// File: verilog/sector_buffer.sv
/*
 * 2048 x 8 true dual-port RAM with registered reads.
 * A write returns the new byte on its own port (write-through).
 * Same-address writes from both ports in one cycle are not resolved.
 */
`timescale 1ns/1ps

module sector_buffer (
	input  logic                 clk_sys,
	input  logic [10:0]          addr_a,
	input  fdc_pkg::byte_t       wdata_a,
	input  logic                 we_a,
	output fdc_pkg::byte_t       rdata_a,
	input  fdc_pkg::buf_addr_t   addr_b,
	input  fdc_pkg::byte_t       wdata_b,
	input  logic                 we_b,
	output fdc_pkg::byte_t       rdata_b
);

	fdc_pkg::byte_t mem [0:2047];

	// SD card side
	always @(posedge clk_sys) begin
		if (we_a) begin
			mem[addr_a] <= wdata_a;
			rdata_a     <= wdata_a;
		end else begin
			rdata_a <= mem[addr_a];
		end
	end

	// controller side
	always @(posedge clk_sys) begin
		if (we_b) begin
			mem[addr_b] <= wdata_b;
			rdata_b     <= wdata_b;
		end else begin
			rdata_b <= mem[addr_b];
		end
	end

endmodule

// File: verilog/sector_geometry.sv
/*
 * Fixed geometry table and image address rule.
 * Layout is track-side-sector; sector numbers start at 1.
 * Codes above 4 fall back to the 26x128 format.
 */
`timescale 1ns/1ps

module sector_geometry (
	input  fdc_pkg::byte_t       disk_track,
	input  logic                 side,
	input  fdc_pkg::byte_t       sector_reg,
	input  fdc_pkg::size_code_t  size_code,
	output fdc_pkg::img_addr_t   img_addr,
	output fdc_pkg::byte_t       sectors_per_track,
	output fdc_pkg::wd_size_t    wd_size,
	output fdc_pkg::blk_idx_t    blk_last
);

	logic [7:0]  head_pos;   // track and side as one index
	logic [15:0] sec_idx;
	logic        unaligned;

	always_comb begin
		case (size_code)
			3'd1: begin
				sectors_per_track = 8'd16;   // 16 x 256
				wd_size           = 2'd1;
			end
			3'd2: begin
				sectors_per_track = 8'd9;
				wd_size           = 2'd2;
			end
			3'd3: begin
				sectors_per_track = 8'd5;    // 5 x 1024
				wd_size           = 2'd3;
			end
			3'd4: begin
				sectors_per_track = 8'd10;
				wd_size           = 2'd2;
			end
			default: begin
				sectors_per_track = 8'd26;   // 26 x 128
				wd_size           = 2'd0;
			end
		endcase
	end

	assign head_pos  = {disk_track[6:0], side};
	assign sec_idx   = 16'(head_pos) * 16'(sectors_per_track) + 16'(sector_reg) - 16'd1;
	assign img_addr  = fdc_pkg::img_addr_t'(sec_idx) << (7 + wd_size);
	assign unaligned = (img_addr[8:0] != 9'd0);

	// extra 512-byte blocks the sector spills into
	always_comb begin
		case (wd_size)
			2'd2:    blk_last = unaligned ? 2'd1 : 2'd0;
			2'd3:    blk_last = unaligned ? 2'd2 : 2'd1;
			default: blk_last = 2'd0;
		endcase
	end

endmodule

// File: verilog/fdc_host_regs.sv
/*
 * Host side of the four-register port.
 * Strobes are qualified by io_en and sampled on ce cycles.
 * Event pulses last one ce cycle; data_wr trails the write edge by one.
 */
`timescale 1ns/1ps

module fdc_host_regs (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                ce,
	input  logic                io_en,
	input  logic                rd,
	input  logic                wr,
	input  fdc_pkg::reg_addr_t  addr,
	input  fdc_pkg::byte_t      din,
	output fdc_pkg::byte_t      dout,
	input  fdc_pkg::byte_t      status_byte,
	input  fdc_pkg::byte_t      track_reg,
	input  fdc_pkg::byte_t      sector_reg,
	input  fdc_pkg::byte_t      buf_byte,
	input  logic                xfer_read,
	output logic                cmd_wr,
	output logic                track_wr,
	output logic                sector_wr,
	output logic                data_wr,
	output logic                status_read_done,
	output logic                data_read_done,
	output fdc_pkg::byte_t      data_reg
);

	logic rde, wre;
	logic old_rd, old_wr;
	logic wr_rise, rd_rise, rd_fall;
	logic data_wr_q;
	fdc_pkg::reg_addr_t cur_addr;   // address of the access in progress

	assign rde = rd & io_en;
	assign wre = wr & io_en;

	assign wr_rise = wre & ~old_wr;
	assign rd_rise = rde & ~old_rd;
	assign rd_fall = old_rd & ~rde;

	// ====================================================================
	// event pulses
	// ====================================================================
	assign cmd_wr    = ce & wr_rise & (addr == fdc_pkg::A_COMMAND);
	assign track_wr  = ce & wr_rise & (addr == fdc_pkg::A_TRACK);
	assign sector_wr = ce & wr_rise & (addr == fdc_pkg::A_SECTOR);
	assign data_wr   = ce & data_wr_q;

	assign status_read_done = ce & rd_fall & (cur_addr == fdc_pkg::A_STATUS);
	assign data_read_done   = ce & rd_fall & (cur_addr == fdc_pkg::A_DATA);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_rd    <= 1'b0;
			old_wr    <= 1'b0;
			cur_addr  <= fdc_pkg::A_STATUS;
			data_wr_q <= 1'b0;
			data_reg  <= '0;
		end else if (ce) begin
			old_rd <= rde;
			old_wr <= wre;
			if (rd_rise || wr_rise)
				cur_addr <= addr;
			data_wr_q <= wr_rise & (addr == fdc_pkg::A_DATA);
			if (wr_rise && (addr == fdc_pkg::A_DATA))
				data_reg <= din;   // seek target or next write byte
		end
	end

	// read-back mux follows the live address
	always_comb begin
		case (addr)
			fdc_pkg::A_STATUS: dout = status_byte;
			fdc_pkg::A_TRACK:  dout = track_reg;
			fdc_pkg::A_SECTOR: dout = sector_reg;
			default:           dout = xfer_read ? buf_byte : data_reg;
		endcase
	end

endmodule

// File: verilog/fdc_sequencer.sv
/*
 * Command FSM: Type I stepping, sector read/write through the SD buffer,
 * force interrupt and the lost-data watchdog.
 * One command at a time; a new command is taken only while idle,
 * except FORCE INTERRUPT. SD back-pressure is waited out without limit.
 */
`timescale 1ns/1ps

module fdc_sequencer (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 ce,
	input  fdc_pkg::byte_t       din,
	input  logic                 cmd_wr,
	input  logic                 track_wr,
	input  logic                 sector_wr,
	input  logic                 data_wr,
	input  logic                 status_read_done,
	input  logic                 data_read_done,
	input  fdc_pkg::byte_t       data_reg,
	input  logic                 wp,
	input  logic                 ready,
	input  fdc_pkg::img_addr_t   img_addr,
	input  fdc_pkg::byte_t       sectors_per_track,
	input  fdc_pkg::wd_size_t    wd_size,
	input  fdc_pkg::blk_idx_t    blk_last,
	output fdc_pkg::byte_t       status_byte,
	output fdc_pkg::byte_t       track_reg,
	output fdc_pkg::byte_t       sector_reg,
	output fdc_pkg::byte_t       disk_track,
	output logic                 xfer_read,
	output logic                 busy,
	output logic                 drq,
	output logic                 intrq,
	output logic                 sd_rd,
	output logic                 sd_wr,
	input  logic                 sd_ack,
	output fdc_pkg::lba_t        sd_lba,
	output fdc_pkg::blk_idx_t    sd_block,
	output fdc_pkg::buf_addr_t   buf_addr,
	output logic                 buf_we
);

	localparam int AD = fdc_pkg::ACK_SYNC_DEPTH;

	fdc_pkg::seq_state_t state;

	logic cmd_mode;          // 0 shows Type I status, 1 Type II
	logic s_wpe, s_headloaded, s_seekerr, s_lostdata, s_wrfault;
	logic write_cmd, multisector, step_dir, sd_busy;
	logic byte_taken;
	logic [AD-1:0] ack;
	logic [12:0] delay_cnt;  // seek, byte and settle delays
	logic [12:0] wd_cnt;
	fdc_pkg::sec_len_t byte_cnt;
	fdc_pkg::blk_idx_t blk_max;
	fdc_pkg::byte_t    next_track;

	assign next_track = (din[6] ? din[5] : step_dir) ? disk_track - 8'd1 : disk_track + 8'd1;
	assign byte_taken = xfer_read ? data_read_done : data_wr;
	assign buf_we     = data_wr & write_cmd & (state == fdc_pkg::S_BYTE_WAIT);
	assign sd_lba     = fdc_pkg::lba_t'(img_addr[19:9]) + fdc_pkg::lba_t'(sd_block);

	assign status_byte = cmd_mode ?
		{~ready, wp & s_wpe, s_wrfault, s_seekerr | ~ready, 1'b0, s_lostdata, drq, busy} :
		{~ready, wp & s_wpe, s_headloaded, s_seekerr | ~ready, 1'b0,
		 disk_track == 8'd0, 1'b0, busy};

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state        <= fdc_pkg::S_IDLE;
			cmd_mode     <= 1'b0;
			{s_wpe, s_headloaded, s_seekerr, s_lostdata, s_wrfault} <= 5'b10000;
			{write_cmd, multisector, step_dir, sd_busy} <= 4'b0000;
			{xfer_read, busy, drq, intrq, sd_rd, sd_wr} <= 6'b000000;
			ack          <= '0;
			delay_cnt    <= '0;
			wd_cnt       <= '0;
			byte_cnt     <= '0;
			buf_addr     <= '0;
			sd_block     <= '0;
			disk_track   <= '0;
			track_reg    <= '0;
			sector_reg   <= 8'd1;
		end else if (ce) begin
			// SD handshake on the synchronized ack
			ack <= {ack[AD-2:0], sd_ack};
			if (ack[AD-1:AD-2] == 2'b01)
				{sd_rd, sd_wr} <= 2'b00;
			if (ack[AD-1:AD-2] == 2'b10)
				sd_busy <= 1'b0;   // block done

			if (status_read_done)
				intrq <= 1'b0;

			case (state)
				fdc_pkg::S_IDLE: ;

				fdc_pkg::S_SEARCH: begin
					if (!ready) begin
						s_seekerr <= 1'b1;
						state     <= fdc_pkg::S_END;
					end else if (delay_cnt != 0) begin
						delay_cnt <= delay_cnt - 13'd1;
					end else if (sector_reg == 8'd0 || sector_reg > sectors_per_track) begin
						s_seekerr <= 1'b1;   // record not found
						state     <= fdc_pkg::S_END;
					end else begin
						byte_cnt <= fdc_pkg::sec_len_t'(11'd128 << wd_size);
						buf_addr <= {2'b00, img_addr[8:0]};
						blk_max  <= blk_last;
						sd_block <= '0;
						state    <= fdc_pkg::S_FETCH_START;
					end
				end

				// fetch also precedes a write, sectors may not fill a block
				fdc_pkg::S_FETCH_START: begin
					sd_rd   <= 1'b1;
					sd_busy <= 1'b1;
					state   <= fdc_pkg::S_FETCH_WAIT;
				end

				fdc_pkg::S_FETCH_WAIT: if (!sd_busy) begin
					sd_block  <= sd_block + 2'd1;
					delay_cnt <= 13'(fdc_pkg::BYTE_DELAY);
					state     <= (sd_block < blk_max) ? fdc_pkg::S_FETCH_START
					                                  : fdc_pkg::S_BYTE_DELAY;
				end

				fdc_pkg::S_BYTE_DELAY: begin
					if (delay_cnt != 0) begin
						delay_cnt <= delay_cnt - 13'd1;
					end else begin
						drq    <= 1'b1;
						wd_cnt <= 13'(fdc_pkg::WATCHDOG_CYCLES);
						state  <= fdc_pkg::S_BYTE_WAIT;
					end
				end

				fdc_pkg::S_BYTE_WAIT: begin
					if (byte_taken || wd_cnt == 0) begin
						drq <= 1'b0;
						if (!byte_taken)
							s_lostdata <= 1'b1;   // byte skipped
						if (byte_cnt == 11'd1) begin
							if (write_cmd) begin
								sd_block <= '0;
								state    <= fdc_pkg::S_FLUSH_START;
							end else if (multisector) begin
								sector_reg <= sector_reg + 8'd1;
								delay_cnt  <= 13'(fdc_pkg::SEEK_DELAY);
								state      <= fdc_pkg::S_SEARCH;
							end else begin
								state <= fdc_pkg::S_END;
							end
						end else begin
							buf_addr  <= buf_addr + 11'd1;
							byte_cnt  <= byte_cnt - 11'd1;
							delay_cnt <= 13'(fdc_pkg::BYTE_DELAY);
							state     <= fdc_pkg::S_BYTE_DELAY;
						end
					end else begin
						wd_cnt <= wd_cnt - 13'd1;
					end
				end

				fdc_pkg::S_FLUSH_START: begin
					sd_wr   <= 1'b1;
					sd_busy <= 1'b1;
					state   <= fdc_pkg::S_FLUSH_WAIT;
				end

				fdc_pkg::S_FLUSH_WAIT: if (!sd_busy) begin
					sd_block <= sd_block + 2'd1;
					if (sd_block < blk_max) begin
						state <= fdc_pkg::S_FLUSH_START;
					end else if (multisector) begin
						sector_reg <= sector_reg + 8'd1;
						delay_cnt  <= 13'(fdc_pkg::SEEK_DELAY);
						state      <= fdc_pkg::S_SEARCH;
					end else begin
						state <= fdc_pkg::S_END;
					end
				end

				fdc_pkg::S_SETTLE: begin
					if (delay_cnt != 0)
						delay_cnt <= delay_cnt - 13'd1;
					else
						state <= fdc_pkg::S_END;
				end

				default: begin   // S_END
					busy      <= 1'b0;
					drq       <= 1'b0;
					intrq     <= 1'b1;
					xfer_read <= 1'b0;
					state     <= fdc_pkg::S_IDLE;
				end
			endcase

			// ====================================================================
			// command decode, overrides the FSM step above
			// ====================================================================
			if (cmd_wr) begin
				intrq <= 1'b0;
				if (din[7:4] == fdc_pkg::CMD_FORCE_INT) begin
					cmd_mode <= 1'b0;
					{s_wrfault, s_seekerr, s_lostdata} <= 3'b000;
					if (state != fdc_pkg::S_IDLE)
						state <= fdc_pkg::S_END;
					else
						{drq, busy} <= 2'b00;
				end else if (state == fdc_pkg::S_IDLE && !din[7]) begin
					// Type I: restore, seek, step
					cmd_mode     <= 1'b0;
					s_wpe        <= 1'b1;
					s_seekerr    <= 1'b0;
					s_headloaded <= din[3];
					busy         <= 1'b1;
					delay_cnt    <= 13'(fdc_pkg::SETTLE_CYCLES + 1);
					state        <= fdc_pkg::S_SETTLE;
					if (din[7:4] == fdc_pkg::CMD_RESTORE) begin
						disk_track <= '0;
						track_reg  <= '0;
					end else if (din[7:4] == fdc_pkg::CMD_SEEK) begin
						disk_track <= data_reg;
						track_reg  <= data_reg;
					end else begin
						if (din[6])
							step_dir <= din[5];   // 1 steps out
						disk_track <= next_track;
						if (din[4])
							track_reg <= next_track;
					end
				end else if (state == fdc_pkg::S_IDLE &&
				             (din[7:5] == fdc_pkg::CMD_READ[3:1] ||
				              din[7:5] == fdc_pkg::CMD_WRITE[3:1])) begin
					cmd_mode    <= 1'b1;
					s_wpe       <= din[5];
					{s_wrfault, s_seekerr, s_lostdata} <= 3'b000;
					busy        <= 1'b1;
					write_cmd   <= din[5];
					xfer_read   <= ~din[5];
					multisector <= din[4];
					delay_cnt   <= 13'(fdc_pkg::SEEK_DELAY);
					state       <= fdc_pkg::S_SEARCH;
					if (din[5] && wp) begin
						s_wrfault <= 1'b1;   // protected disk, no transfer
						delay_cnt <= 13'(fdc_pkg::SETTLE_CYCLES + 1);
						state     <= fdc_pkg::S_SETTLE;
					end
				end
				// read address, read track and write track fall through
			end

			if (track_wr && !busy)
				track_reg <= din;
			if (sector_wr && !busy)
				sector_reg <= din;
		end
	end

endmodule

// File: verilog/wd_fdc.sv
/*
 * WD1793-style floppy controller backed by an SD card image.
 * Fixed geometries only, selected by size_code (0..4).
 * READ ADDRESS, READ TRACK and WRITE TRACK are ignored.
 * The status index bit always reads 0.
 */
`timescale 1ns/1ps

module wd_fdc (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 ce,
	input  logic                 io_en,
	input  logic                 rd,
	input  logic                 wr,
	input  fdc_pkg::reg_addr_t   addr,
	input  fdc_pkg::byte_t       din,
	output fdc_pkg::byte_t       dout,
	output logic                 drq,
	output logic                 intrq,
	output logic                 busy,
	input  logic                 wp,
	input  logic                 side,
	input  logic                 ready,
	input  fdc_pkg::size_code_t  size_code,
	output fdc_pkg::lba_t        sd_lba,
	output logic                 sd_rd,
	output logic                 sd_wr,
	input  logic                 sd_ack,
	input  logic [8:0]           sd_buff_addr,
	input  fdc_pkg::byte_t       sd_buff_dout,
	output fdc_pkg::byte_t       sd_buff_din,
	input  logic                 sd_buff_wr
);

	logic cmd_wr, track_wr, sector_wr, data_wr;
	logic status_read_done, data_read_done;
	logic xfer_read, buf_we;

	fdc_pkg::byte_t      data_reg, status_byte, track_reg, sector_reg;
	fdc_pkg::byte_t      disk_track, buf_byte, sectors_per_track;
	fdc_pkg::img_addr_t  img_addr;
	fdc_pkg::wd_size_t   wd_size;
	fdc_pkg::blk_idx_t   blk_last, sd_block;
	fdc_pkg::buf_addr_t  buf_addr;

	fdc_host_regs u_regs (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.ce               (ce),
		.io_en            (io_en),
		.rd               (rd),
		.wr               (wr),
		.addr             (addr),
		.din              (din),
		.dout             (dout),
		.status_byte      (status_byte),
		.track_reg        (track_reg),
		.sector_reg       (sector_reg),
		.buf_byte         (buf_byte),
		.xfer_read        (xfer_read),
		.cmd_wr           (cmd_wr),
		.track_wr         (track_wr),
		.sector_wr        (sector_wr),
		.data_wr          (data_wr),
		.status_read_done (status_read_done),
		.data_read_done   (data_read_done),
		.data_reg         (data_reg)
	);

	fdc_sequencer u_seq (
		.clk_sys           (clk_sys),
		.reset             (reset),
		.ce                (ce),
		.din               (din),
		.cmd_wr            (cmd_wr),
		.track_wr          (track_wr),
		.sector_wr         (sector_wr),
		.data_wr           (data_wr),
		.status_read_done  (status_read_done),
		.data_read_done    (data_read_done),
		.data_reg          (data_reg),
		.wp                (wp),
		.ready             (ready),
		.img_addr          (img_addr),
		.sectors_per_track (sectors_per_track),
		.wd_size           (wd_size),
		.blk_last          (blk_last),
		.status_byte       (status_byte),
		.track_reg         (track_reg),
		.sector_reg        (sector_reg),
		.disk_track        (disk_track),
		.xfer_read         (xfer_read),
		.busy              (busy),
		.drq               (drq),
		.intrq             (intrq),
		.sd_rd             (sd_rd),
		.sd_wr             (sd_wr),
		.sd_ack            (sd_ack),
		.sd_lba            (sd_lba),
		.sd_block          (sd_block),
		.buf_addr          (buf_addr),
		.buf_we            (buf_we)
	);

	sector_geometry u_geom (
		.disk_track        (disk_track),
		.side              (side),
		.sector_reg        (sector_reg),
		.size_code         (size_code),
		.img_addr          (img_addr),
		.sectors_per_track (sectors_per_track),
		.wd_size           (wd_size),
		.blk_last          (blk_last)
	);

	// port a belongs to the SD card, port b to the host transfer
	sector_buffer u_buf (
		.clk_sys (clk_sys),
		.addr_a  ({sd_block, sd_buff_addr}),
		.wdata_a (sd_buff_dout),
		.we_a    (sd_buff_wr & sd_ack),
		.rdata_a (sd_buff_din),
		.addr_b  (buf_addr),
		.wdata_b (data_reg),
		.we_b    (buf_we),
		.rdata_b (buf_byte)
	);

endmodule

// File: tests/wd_fdc_assertions.sv
/*
 * Protocol checks bound into every wd_fdc instance.
 * drq may outlast a forced end of command only through the end state.
 */
`timescale 1ns/1ps

module wd_fdc_assertions (
	input logic                 clk_sys,
	input logic                 reset,
	input logic                 busy,
	input logic                 drq,
	input logic                 intrq,
	input logic                 sd_rd,
	input logic                 sd_wr,
	input fdc_pkg::seq_state_t  state
);

	int unsigned fail_count = 0;   // read by the testbench summary

	drq_within_busy: assert property (@(posedge clk_sys) disable iff (reset) drq |-> busy)
		else begin
			$error("drq high while the controller is not busy");
			fail_count++;
		end

	one_sd_request: assert property (@(posedge clk_sys) disable iff (reset) !(sd_rd && sd_wr))
		else begin
			$error("sd_rd and sd_wr requested together");
			fail_count++;
		end

	no_irq_while_busy: assert property (@(posedge clk_sys) disable iff (reset) !(intrq && busy))
		else begin
			$error("intrq high during a command");
			fail_count++;
		end

	// drq belongs to the byte handshake or to a forced end
	drq_in_byte_phase: assert property (@(posedge clk_sys) disable iff (reset)
		drq |-> (state == fdc_pkg::S_BYTE_WAIT || state == fdc_pkg::S_END))
		else begin
			$error("drq high outside the byte phase");
			fail_count++;
		end

	reset_clears_busy: assert property (@(posedge clk_sys) reset |=> !busy)
		else begin
			$error("busy set in the cycle after reset");
			fail_count++;
		end

endmodule

bind wd_fdc wd_fdc_assertions u_assert (
	.clk_sys (clk_sys),
	.reset   (reset),
	.busy    (busy),
	.drq     (drq),
	.intrq   (intrq),
	.sd_rd   (sd_rd),
	.sd_wr   (sd_wr),
	.state   (u_seq.state)
);

// File: tests/wd_fdc_tb.sv
/*
 * Directed tests for wd_fdc with ce tied high.
 * The SD model holds a 1 MB image and serves one 512-byte block per request,
 * so test tracks stay low enough to keep every block inside the image.
 */
`timescale 1ns/1ps

module wd_fdc_tb;

	localparam int IMG_BYTES  = 1 << 20;
	localparam int DRQ_LIMIT  = 8000;     // seek delay plus up to three fetches
	localparam int DONE_LIMIT = 20000;
	localparam int LOST_LIMIT = 700000;   // every byte of a sector runs out

	logic clk_sys, reset, io_en, rd, wr;
	logic wp, side, ready;
	logic drq, intrq, busy;
	logic sd_rd, sd_wr, sd_ack, sd_buff_wr;
	logic [8:0] sd_buff_addr;
	fdc_pkg::reg_addr_t  addr;
	fdc_pkg::byte_t      din, dout, sd_buff_dout, sd_buff_din;
	fdc_pkg::size_code_t size_code;
	fdc_pkg::lba_t       sd_lba;

	fdc_pkg::byte_t img [0:IMG_BYTES-1];   // SD card image
	fdc_pkg::lba_t  rd_log[$];
	fdc_pkg::lba_t  wr_log[$];

	string test_name;
	int    errors, checks, test_start_errors;

	wd_fdc DUT (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.ce           (1'b1),
		.io_en        (io_en),
		.rd           (rd),
		.wr           (wr),
		.addr         (addr),
		.din          (din),
		.dout         (dout),
		.drq          (drq),
		.intrq        (intrq),
		.busy         (busy),
		.wp           (wp),
		.side         (side),
		.ready        (ready),
		.size_code    (size_code),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.sd_ack       (sd_ack),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_dout (sd_buff_dout),
		.sd_buff_din  (sd_buff_din),
		.sd_buff_wr   (sd_buff_wr)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ======================================================================
	// SD card model
	// ======================================================================
	task automatic serve_block(input logic is_read, input fdc_pkg::lba_t lba);
		int unsigned base;
		base = lba * 512;
		sd_ack = 1'b1;
		for (int i = 0; i < 512; i++) begin
			@(negedge clk_sys);
			sd_buff_addr = 9'(i);
			if (is_read) begin
				sd_buff_dout = img[base + i];
				sd_buff_wr   = 1'b1;
			end else begin
				@(negedge clk_sys);   // registered buffer read
				img[base + i] = sd_buff_din;
			end
		end
		@(negedge clk_sys);
		sd_buff_wr = 1'b0;
		sd_ack     = 1'b0;
	endtask

	initial begin : sd_card
		sd_ack       = 1'b0;
		sd_buff_wr   = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		forever begin
			@(negedge clk_sys);
			if (sd_rd) begin
				rd_log.push_back(sd_lba);
				serve_block(1'b1, sd_lba);
			end else if (sd_wr) begin
				wr_log.push_back(sd_lba);
				serve_block(1'b0, sd_lba);
			end
		end
	end

	// ======================================================================
	// reference geometry and checks
	// ======================================================================
	function automatic int unsigned sector_bytes(input fdc_pkg::size_code_t code);
		case (code)
			3'd1:       return 256;
			3'd2, 3'd4: return 512;
			3'd3:       return 1024;
			default:    return 128;
		endcase
	endfunction

	function automatic int unsigned track_sectors(input fdc_pkg::size_code_t code);
		case (code)
			3'd1:    return 16;
			3'd2:    return 9;
			3'd3:    return 5;
			3'd4:    return 10;
			default: return 26;
		endcase
	endfunction

	// track-side-sector layout with sectors numbered from 1
	function automatic int unsigned image_addr(input fdc_pkg::size_code_t code,
			input int trk, input logic sd, input int sec);
		return ((trk * 2 + sd) * track_sectors(code) + sec - 1) * sector_bytes(code);
	endfunction

	function automatic int block_count(input fdc_pkg::size_code_t code, input int unsigned a);
		return ((a % 512) + sector_bytes(code) - 1) / 512 + 1;
	endfunction

	task automatic expect_eq(input string what, input int expected, input int actual);
		checks++;
		assert (expected == actual) else begin
			errors++;
			$display("ERR %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
		end
	endtask

	task automatic start_test(input string name);
		test_name         = name;
		test_start_errors = errors;
	endtask

	task automatic finish_test();
		$display("%s: done, %0d error(s)", test_name, errors - test_start_errors);
	endtask

	// ======================================================================
	// host bus
	// ======================================================================
	task automatic host_write(input fdc_pkg::reg_addr_t a, input fdc_pkg::byte_t d);
		@(negedge clk_sys);
		addr  = a;
		din   = d;
		io_en = 1'b1;
		wr    = 1'b1;
		@(negedge clk_sys);
		io_en = 1'b0;
		wr    = 1'b0;
	endtask

	task automatic host_read(input fdc_pkg::reg_addr_t a, output fdc_pkg::byte_t d);
		@(negedge clk_sys);
		addr  = a;
		io_en = 1'b1;
		rd    = 1'b1;
		@(negedge clk_sys);
		d     = dout;
		io_en = 1'b0;
		rd    = 1'b0;
	endtask

	task automatic wait_drq(input int limit, output bit ok);
		int n;
		n = 0;
		@(negedge clk_sys);   // previous byte clears drq first
		while (!drq && n < limit) begin
			@(negedge clk_sys);
			n++;
		end
		ok = drq;
		assert (ok) else begin
			errors++;
			$display("%s: no drq within %0d cycles", test_name, limit);
		end
	endtask

	task automatic wait_idle(input int limit, output int cycles);
		cycles = 0;
		while (busy && cycles < limit) begin
			cycles++;
			@(negedge clk_sys);
		end
		assert (!busy) else begin
			errors++;
			$display("%s: controller still busy after %0d cycles", test_name, limit);
		end
	endtask

	task automatic end_command(input int limit, output fdc_pkg::byte_t st);
		int cyc;
		wait_idle(limit, cyc);
		expect_eq("intrq at end", 1, intrq);
		host_read(fdc_pkg::A_STATUS, st);
	endtask

	task automatic seek_to(input int trk);
		int cyc;
		host_write(fdc_pkg::A_DATA, 8'(trk));
		host_write(fdc_pkg::A_COMMAND, 8'h10);
		wait_idle(DONE_LIMIT, cyc);
	endtask

	task automatic read_bytes(input int unsigned a, input int n);
		fdc_pkg::byte_t b;
		bit ok;
		for (int k = 0; k < n; k++) begin
			wait_drq(DRQ_LIMIT, ok);
			if (!ok)
				break;
			host_read(fdc_pkg::A_DATA, b);
			expect_eq("read byte", img[a + k], b);
		end
	endtask

	// cmd is 80 for read and A0 for write
	task automatic start_sector_cmd(input fdc_pkg::size_code_t code, input int trk,
			input logic sd, input int sec, input fdc_pkg::byte_t cmd);
		seek_to(trk);
		size_code = code;
		side      = sd;
		host_write(fdc_pkg::A_SECTOR, 8'(sec));
		rd_log.delete();
		wr_log.delete();
		host_write(fdc_pkg::A_COMMAND, cmd);
	endtask

	// ======================================================================
	// directed tests
	// ======================================================================
	task automatic reset_regs();
		fdc_pkg::byte_t b;
		start_test("reset_regs");
		expect_eq("busy", 0, busy);
		expect_eq("drq", 0, drq);
		expect_eq("intrq", 0, intrq);
		expect_eq("sd requests", 0, {sd_rd, sd_wr});
		host_read(fdc_pkg::A_STATUS, b);
		expect_eq("status busy", 0, b[0]);
		expect_eq("status track0", 1, b[2]);
		host_write(fdc_pkg::A_TRACK, 8'h2A);
		host_read(fdc_pkg::A_TRACK, b);
		expect_eq("track reg", 8'h2A, b);
		host_write(fdc_pkg::A_SECTOR, 8'h07);
		host_read(fdc_pkg::A_SECTOR, b);
		expect_eq("sector reg", 8'h07, b);
		finish_test();
	endtask

	task automatic seek_step();
		fdc_pkg::byte_t b;
		int cyc;
		start_test("seek_step");
		host_write(fdc_pkg::A_DATA, 8'd5);
		host_write(fdc_pkg::A_COMMAND, 8'h10);
		expect_eq("busy after seek", 1, busy);
		wait_idle(DONE_LIMIT, cyc);
		expect_eq("busy cycles", fdc_pkg::SETTLE_CYCLES + 3, cyc);
		expect_eq("intrq after seek", 1, intrq);
		host_read(fdc_pkg::A_TRACK, b);
		expect_eq("track after seek", 5, b);
		host_write(fdc_pkg::A_COMMAND, 8'h50);   // step in with track update
		wait_idle(DONE_LIMIT, cyc);
		host_read(fdc_pkg::A_TRACK, b);
		expect_eq("track after step in", 6, b);
		host_write(fdc_pkg::A_COMMAND, 8'h00);
		wait_idle(DONE_LIMIT, cyc);
		host_read(fdc_pkg::A_TRACK, b);
		expect_eq("track after restore", 0, b);
		expect_eq("intrq before status read", 1, intrq);
		host_read(fdc_pkg::A_STATUS, b);
		expect_eq("status track0", 1, b[2]);
		@(negedge clk_sys);
		expect_eq("intrq after status read", 0, intrq);
		finish_test();
	endtask

	task automatic read_case(input fdc_pkg::size_code_t code, input int trk,
			input logic sd, input int sec);
		fdc_pkg::byte_t st;
		int unsigned a;
		a = image_addr(code, trk, sd, sec);
		start_sector_cmd(code, trk, sd, sec, 8'h80);
		read_bytes(a, sector_bytes(code));
		end_command(DONE_LIMIT, st);
		expect_eq("read status", 0, st & 8'h37);
		expect_eq("first lba", a >> 9, (rd_log.size() > 0) ? int'(rd_log[0]) : -1);
		expect_eq("fetched blocks", block_count(code, a), rd_log.size());
	endtask

	task automatic write_case(input fdc_pkg::size_code_t code, input int trk,
			input logic sd, input int sec);
		fdc_pkg::byte_t data_q[$];
		fdc_pkg::byte_t b, st;
		int unsigned a;
		bit ok;
		a = image_addr(code, trk, sd, sec);
		start_sector_cmd(code, trk, sd, sec, 8'hA0);
		for (int k = 0; k < sector_bytes(code); k++) begin
			wait_drq(DRQ_LIMIT, ok);
			if (!ok)
				break;
			b = 8'($urandom());
			data_q.push_back(b);
			host_write(fdc_pkg::A_DATA, b);
		end
		end_command(DONE_LIMIT, st);
		expect_eq("write status", 0, st & 8'h37);
		expect_eq("flush lba", a >> 9, (wr_log.size() > 0) ? int'(wr_log[0]) : -1);
		expect_eq("flushed blocks", block_count(code, a), wr_log.size());
		foreach (data_q[k])
			expect_eq("image byte", data_q[k], img[a + k]);
	endtask

	task automatic write_protect();
		fdc_pkg::byte_t st;
		wp = 1'b1;
		start_sector_cmd(3'd0, 1, 1'b0, 1, 8'hA0);
		end_command(DONE_LIMIT, st);
		expect_eq("write fault bit", 1, st[5]);
		expect_eq("sd writes", 0, wr_log.size());
		wp = 1'b0;
	endtask

	task automatic multi_and_seek_error();
		fdc_pkg::byte_t st;
		int unsigned a;
		start_test("multi_sector");
		a = image_addr(3'd0, 9, 1'b1, 24);
		start_sector_cmd(3'd0, 9, 1'b1, 24, 8'h90);   // sectors 24 to 26
		read_bytes(a, 3 * 128);
		end_command(DONE_LIMIT, st);
		expect_eq("lost data bit", 0, st[2]);
		finish_test();

		start_test("seek_error");
		start_sector_cmd(3'd0, 2, 1'b0, 0, 8'h80);
		end_command(DONE_LIMIT, st);
		expect_eq("rnf for sector 0", 1, st[4]);
		start_sector_cmd(3'd2, 2, 1'b0, 10, 8'h80);   // 9 sectors on this format
		end_command(DONE_LIMIT, st);
		expect_eq("rnf past track end", 1, st[4]);
		expect_eq("fetches on rnf", 0, rd_log.size());
		finish_test();
	endtask

	task automatic force_and_lost();
		fdc_pkg::byte_t st;
		bit ok;
		int cyc;
		start_test("force_int");
		start_sector_cmd(3'd0, 3, 1'b0, 1, 8'h80);
		wait_drq(DRQ_LIMIT, ok);
		host_write(fdc_pkg::A_COMMAND, 8'hD0);
		wait_idle(16, cyc);
		expect_eq("intrq after force", 1, intrq);
		host_read(fdc_pkg::A_STATUS, st);
		finish_test();

		start_test("lost_data");
		start_sector_cmd(3'd0, 3, 1'b0, 2, 8'h80);
		end_command(LOST_LIMIT, st);   // drq never serviced
		expect_eq("lost data bit", 1, st[2]);
		finish_test();
	endtask

	// ======================================================================
	// main sequence
	// ======================================================================
	initial begin : main
		reset     = 1'b1;
		io_en     = 1'b0;
		rd        = 1'b0;
		wr        = 1'b0;
		addr      = '0;
		din       = '0;
		wp        = 1'b0;
		side      = 1'b0;
		ready     = 1'b1;
		size_code = '0;
		errors    = 0;
		checks    = 0;
		void'($urandom(68315));
		for (int i = 0; i < IMG_BYTES; i++)
			img[i] = 8'($urandom());
		repeat (8) @(negedge clk_sys);
		reset = 1'b0;

		reset_regs();
		seek_step();

		start_test("read_sector");
		read_case(3'd0, 3, 1'b0, 5);
		read_case(3'd1, 2, 1'b1, 16);
		read_case(3'd2, 4, 1'b1, 9);
		read_case(3'd3, 1, 1'b0, 3);
		read_case(3'd4, 7, 1'b1, 10);
		finish_test();

		start_test("write_sector");
		write_case(3'd0, 2, 1'b0, 1);
		write_case(3'd3, 5, 1'b1, 4);
		write_protect();
		finish_test();

		multi_and_seek_error();
		force_and_lost();

		if (DUT.u_assert.fail_count != 0) begin
			errors += int'(DUT.u_assert.fail_count);
			$display("bound protocol assertions failed %0d time(s)",
				DUT.u_assert.fail_count);
		end

		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: wd_fdc.f
verilog/fdc_pkg.sv
verilog/sector_buffer.sv
verilog/sector_geometry.sv
verilog/fdc_host_regs.sv
verilog/fdc_sequencer.sv
verilog/wd_fdc.sv
tests/wd_fdc_assertions.sv
tests/wd_fdc_tb.sv

// File: Bender.yml
package:
  name: wd_fdc

sources:
  - verilog/fdc_pkg.sv
  - verilog/sector_buffer.sv
  - verilog/sector_geometry.sv
  - verilog/fdc_host_regs.sv
  - verilog/fdc_sequencer.sv
  - verilog/wd_fdc.sv
  - target: test
    files:
      - tests/wd_fdc_assertions.sv
      - tests/wd_fdc_tb.sv
